// ==== hw/spiUnitPkg.sv ====
`default_nettype none

package spiUnitPkg;

	//----------------------------------------------------------------------------
	// Frame encodings
	//----------------------------------------------------------------------------

	// Command byte, any other value is an unknown command
	typedef enum logic [7:0]
	{
		opWrite = 8'h02,
		opRead  = 8'h03
	} spiOpcode;

	// Decoder position inside a frame
	typedef enum logic [2:0]
	{
		sIdle,
		sCmd,
		sAdrs,
		sLen,
		sDummy,
		sData,
		sSkip
	} decodeState;

	// Length field counts whole bus words
	localparam int lenBits  = 16;
	// USI bus word
	localparam int wordBits = 32;

endpackage

`default_nettype wire

// ==== hw/spiPinSync.sv ====
`timescale 1ns/10ps
`default_nettype none

module spiPinSync
(
	input  wire  sysClk,
	input  wire  rstN,
	input  wire  spiSck,
	input  wire  spiCs,
	input  wire  spiMosi,
	output logic sckRise,
	output logic sckFall,
	output logic csActive,
	output logic csFall,
	output logic csRise,
	output logic mosiBit
);

	// Stage 0 catches the pin, stage 1 is safe to use
	logic [1:0] sckSync;
	logic [1:0] csSync;
	logic [1:0] mosiSync;
	// Previous settled samples for edge detection
	logic       sckPrev;
	logic       csPrev;

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			// SCK idles low in mode 0, CS idles high
			sckSync  <= 2'b00;
			csSync   <= 2'b11;
			mosiSync <= 2'b00;
			sckPrev  <= 1'b0;
			csPrev   <= 1'b1;
		end
		else
		begin
			sckSync  <= {sckSync[0], spiSck};
			csSync   <= {csSync[0], spiCs};
			mosiSync <= {mosiSync[0], spiMosi};
			sckPrev  <= sckSync[1];
			csPrev   <= csSync[1];
		end
	end

	//----------------------------------------------------------------------------
	// Edge pulses, one sysClk wide
	//----------------------------------------------------------------------------
	assign sckRise  = sckSync[1] & ~sckPrev;
	assign sckFall  = ~sckSync[1] & sckPrev;
	assign csActive = ~csSync[1];
	assign csFall   = ~csSync[1] & csPrev;
	assign csRise   = csSync[1] & ~csPrev;
	// MOSI settles half an SCK period before the rise
	assign mosiBit  = mosiSync[1];

endmodule

`default_nettype wire

// ==== hw/spiFrameDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module spiFrameDecode
#(
	parameter int pBusAdrsBit = 16
)
(
	input  wire                              sysClk,
	input  wire                              rstN,
	input  wire                              sckRise,
	input  wire                              csActive,
	input  wire                              csFall,
	input  wire                              csRise,
	input  wire                              mosiBit,
	output logic                             cmdValid,
	output spiUnitPkg::spiOpcode             cmdOp,
	output logic [pBusAdrsBit-1:0]           cmdAdrs,
	output logic [spiUnitPkg::lenBits-1:0]   cmdLen,
	input  wire                              cmdReady,
	output logic                             wordValid,
	output logic [spiUnitPkg::wordBits-1:0]  wordData,
	input  wire                              wordReady,
	output logic                             frameAbort
);

	localparam logic [spiUnitPkg::lenBits-1:0] oneWord = 1;

	spiUnitPkg::decodeState              state;
	logic [4:0]                          bitCnt;
	logic [4:0]                          fieldLast;
	logic [spiUnitPkg::wordBits-1:0]     shiftReg;
	logic [spiUnitPkg::wordBits-1:0]     shiftNext;
	logic [spiUnitPkg::lenBits-1:0]      wordsLeft;
	logic [spiUnitPkg::lenBits-1:0]      lenNext;
	spiUnitPkg::spiOpcode                opNext;
	logic                                shifting;
	logic                                fieldEnd;
	logic                                wordDone;

	//----------------------------------------------------------------------------
	// MOSI deserializer
	//----------------------------------------------------------------------------

	// Last bit index of the current field
	always_comb
	begin
		case (state)
			spiUnitPkg::sCmd, spiUnitPkg::sDummy: fieldLast = 5'd7;
			spiUnitPkg::sAdrs, spiUnitPkg::sLen:  fieldLast = 5'd15;
			default:                              fieldLast = 5'd31;
		endcase
	end

	// Only fields in flight take bits
	assign shifting  = sckRise && csActive &&
		(state != spiUnitPkg::sIdle) && (state != spiUnitPkg::sSkip);
	assign fieldEnd  = shifting && (bitCnt == fieldLast);
	assign wordDone  = fieldEnd && (state == spiUnitPkg::sData);
	// MSB first
	assign shiftNext = {shiftReg[spiUnitPkg::wordBits-2:0], mosiBit};
	assign opNext    = spiUnitPkg::spiOpcode'(shiftNext[7:0]);
	assign lenNext   = shiftNext[spiUnitPkg::lenBits-1:0];

	// Any CS rise while a frame is open
	assign frameAbort = csRise && (state != spiUnitPkg::sIdle);

	//----------------------------------------------------------------------------
	// Field sequencer
	//----------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state     <= spiUnitPkg::sIdle;
			bitCnt    <= '0;
			wordsLeft <= '0;
			cmdValid  <= 1'b0;
			wordValid <= 1'b0;
		end
		else if (csRise)
		begin
			// Frame closed, drop anything not yet taken
			state     <= spiUnitPkg::sIdle;
			cmdValid  <= 1'b0;
			wordValid <= 1'b0;
		end
		else if (csFall)
		begin
			state  <= spiUnitPkg::sCmd;
			bitCnt <= '0;
		end
		else
		begin
			if (cmdValid && cmdReady)
				cmdValid <= 1'b0;
			if (wordValid && wordReady)
				wordValid <= 1'b0;
			if (shifting)
				bitCnt <= fieldEnd ? 5'd0 : bitCnt + 5'd1;

			if (fieldEnd)
			begin
				case (state)
					spiUnitPkg::sCmd:
					begin
						// Unknown command, skip rest of frame
						if (opNext == spiUnitPkg::opWrite || opNext == spiUnitPkg::opRead)
							state <= spiUnitPkg::sAdrs;
						else
							state <= spiUnitPkg::sSkip;
					end
					spiUnitPkg::sAdrs:
						state <= spiUnitPkg::sLen;
					spiUnitPkg::sLen:
					begin
						// Header goes out once, zero length included
						cmdValid  <= 1'b1;
						wordsLeft <= lenNext;
						if (lenNext == '0)
							state <= spiUnitPkg::sSkip;
						else if (cmdOp == spiUnitPkg::opRead)
							state <= spiUnitPkg::sDummy;
						else
							state <= spiUnitPkg::sData;
					end
					spiUnitPkg::sData:
					begin
						wordValid <= 1'b1;
						wordsLeft <= wordsLeft - oneWord;
						// Extra bytes past the length are ignored
						if (wordsLeft == oneWord)
							state <= spiUnitPkg::sSkip;
					end
					default:
						// Dummy byte ends decode work for a read
						state <= spiUnitPkg::sSkip;
				endcase
			end
		end
	end

	// Field payloads
	always_ff @(posedge sysClk)
	begin
		if (shifting)
			shiftReg <= shiftNext;
		if (fieldEnd && state == spiUnitPkg::sCmd)
			cmdOp <= opNext;
		if (fieldEnd && state == spiUnitPkg::sAdrs)
			cmdAdrs <= shiftNext[pBusAdrsBit-1:0];
		if (fieldEnd && state == spiUnitPkg::sLen)
			cmdLen <= lenNext;
		if (wordDone)
			wordData <= shiftNext;
	end

	//----------------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------------

	// Executor must drain a word within one word time
	wordOverrun: assert property (@(posedge sysClk) disable iff (!rstN)
		wordDone |-> !wordValid)
		else $error("write word completed while the previous one was still pending");

	// Master keeps SCK quiet outside chip select
	sckOutsideCs: assert property (@(posedge sysClk) disable iff (!rstN)
		(state == spiUnitPkg::sData) |-> !(sckRise && !csActive))
		else $error("SCK rise seen with chip select released during data");

endmodule

`default_nettype wire

// ==== hw/usiBusExec.sv ====
`timescale 1ns/10ps
`default_nettype none

module usiBusExec
#(
	parameter int pBusAdrsBit = 16
)
(
	input  wire                              sysClk,
	input  wire                              rstN,
	input  wire                              cmdValid,
	input  var spiUnitPkg::spiOpcode         cmdOp,
	input  wire  [pBusAdrsBit-1:0]           cmdAdrs,
	input  wire  [spiUnitPkg::lenBits-1:0]   cmdLen,
	output logic                             cmdReady,
	input  wire                              wordValid,
	input  wire  [spiUnitPkg::wordBits-1:0]  wordData,
	output logic                             wordReady,
	input  wire                              frameAbort,
	input  wire                              csRise,
	input  wire                              csActive,
	output logic [pBusAdrsBit-1:0]           usiAdrs,
	output logic [spiUnitPkg::wordBits-1:0]  usiWd,
	output logic                             usiWEd,
	output logic                             usiREd,
	input  wire  [spiUnitPkg::wordBits-1:0]  usiRd,
	output logic                             rdValid,
	output logic [spiUnitPkg::wordBits-1:0]  rdData,
	input  wire                              rdReady,
	output logic                             busMonopoly,
	output logic                             spiIntr
);

	localparam logic [pBusAdrsBit-1:0]         adrsStep = 4;
	localparam logic [spiUnitPkg::lenBits-1:0] oneWord  = 1;

	// Bus access sequencer
	typedef enum logic [2:0]
	{
		exIdle,
		exWrite,
		exRdReq,
		exRdWait,
		exRdCap,
		exRdOffer,
		exDone
	} execState;

	execState                        state;
	logic [pBusAdrsBit-1:0]          curAdrs;
	logic [spiUnitPkg::lenBits-1:0]  remaining;
	logic                            frameKnown;
	logic                            cmdTake;
	logic                            wordTake;
	logic                            knownOp;

	// One header per frame
	assign cmdReady  = (state == exIdle);
	// Hold off while the previous strobe updates the address
	assign wordReady = (state == exWrite) && !usiWEd;
	assign cmdTake   = cmdValid && cmdReady;
	assign wordTake  = wordValid && wordReady;
	assign knownOp   = (cmdOp == spiUnitPkg::opWrite) || (cmdOp == spiUnitPkg::opRead);

	// Address stays put through the strobe cycle
	assign usiAdrs     = curAdrs;
	// Bus owned for the whole chip select window
	assign busMonopoly = csActive;

	//----------------------------------------------------------------------------
	// Sequencer
	//----------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state      <= exIdle;
			curAdrs    <= '0;
			remaining  <= '0;
			frameKnown <= 1'b0;
			usiWEd     <= 1'b0;
			usiREd     <= 1'b0;
			rdValid    <= 1'b0;
			spiIntr    <= 1'b0;
		end
		else
		begin
			// Completed frame, judged before the abort clears state
			spiIntr <= csRise && frameKnown && (remaining == '0);

			if (frameAbort)
			begin
				state      <= exIdle;
				frameKnown <= 1'b0;
				usiWEd     <= 1'b0;
				usiREd     <= 1'b0;
				rdValid    <= 1'b0;
			end
			else
			begin
				usiWEd <= wordTake;
				usiREd <= (state == exRdReq);

				case (state)
					exIdle:
					begin
						if (cmdTake)
						begin
							curAdrs    <= cmdAdrs;
							remaining  <= cmdLen;
							frameKnown <= knownOp;
							if (!knownOp || cmdLen == '0)
								state <= exDone;
							else if (cmdOp == spiUnitPkg::opRead)
								state <= exRdReq;
							else
								state <= exWrite;
						end
					end
					exWrite:
					begin
						// Step after each strobe
						if (usiWEd)
						begin
							curAdrs   <= curAdrs + adrsStep;
							remaining <= remaining - oneWord;
							if (remaining == oneWord)
								state <= exDone;
						end
					end
					exRdReq:
						state <= exRdWait;
					exRdWait:
					begin
						// Strobe cycle
						curAdrs   <= curAdrs + adrsStep;
						remaining <= remaining - oneWord;
						state     <= exRdCap;
					end
					exRdCap:
					begin
						// Read data valid now
						rdValid <= 1'b1;
						state   <= exRdOffer;
					end
					exRdOffer:
					begin
						// Next fetch only once MISO side took this word
						if (rdReady)
						begin
							rdValid <= 1'b0;
							state   <= (remaining == '0) ? exDone : exRdReq;
						end
					end
					default:
						state <= exDone;
				endcase
			end
		end
	end

	// Bus payload
	always_ff @(posedge sysClk)
	begin
		if (wordTake)
			usiWd <= wordData;
		if (state == exRdCap)
			rdData <= usiRd;
	end

	//----------------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------------
	strobeExclusive: assert property (@(posedge sysClk) disable iff (!rstN)
		!(usiWEd && usiREd))
		else $error("write and read strobe asserted in the same cycle");

	// No bus traffic outside the chip select window
	strobeOwned: assert property (@(posedge sysClk) disable iff (!rstN)
		(usiWEd || usiREd) |-> busMonopoly)
		else $error("bus strobe issued without bus ownership");

endmodule

`default_nettype wire

// ==== hw/misoResult.sv ====
`timescale 1ns/10ps
`default_nettype none

module misoResult
(
	input  wire                              sysClk,
	input  wire                              rstN,
	input  wire                              sckFall,
	input  wire                              csActive,
	input  wire                              csFall,
	input  wire                              rdValid,
	input  wire  [spiUnitPkg::wordBits-1:0]  rdData,
	output logic                             rdReady,
	output logic                             spiMiso
);

	// One word of slack between bus and shifter
	logic [spiUnitPkg::wordBits-1:0] bufData;
	logic [spiUnitPkg::wordBits-1:0] shiftReg;
	logic                            bufFull;
	// Past the header and dummy byte
	logic                            dataPhase;
	logic [5:0]                      fallCnt;
	logic                            shiftEdge;
	logic                            loadNow;
	logic                            rdTake;

	assign rdReady   = !bufFull;
	assign rdTake    = rdValid && rdReady;
	assign shiftEdge = sckFall && csActive;
	// Fall 47 puts bit 48 on the line, then every 32 falls
	assign loadNow   = shiftEdge &&
		(dataPhase ? (fallCnt[4:0] == 5'd31) : (fallCnt == 6'd47));

	//----------------------------------------------------------------------------
	// Shifter
	//----------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			bufFull   <= 1'b0;
			dataPhase <= 1'b0;
			fallCnt   <= '0;
			shiftReg  <= '0;
			spiMiso   <= 1'b0;
		end
		else if (csFall)
		begin
			// New frame, forget anything left over
			bufFull   <= 1'b0;
			dataPhase <= 1'b0;
			fallCnt   <= '0;
			shiftReg  <= '0;
			spiMiso   <= 1'b0;
		end
		else
		begin
			if (!csActive)
				spiMiso <= 1'b0;
			else if (loadNow)
			begin
				// Empty buffer means zeros
				dataPhase <= 1'b1;
				fallCnt   <= '0;
				bufFull   <= 1'b0;
				spiMiso   <= bufFull & bufData[spiUnitPkg::wordBits-1];
				shiftReg  <= bufFull ? {bufData[spiUnitPkg::wordBits-2:0], 1'b0} : '0;
			end
			else if (shiftEdge)
			begin
				fallCnt  <= fallCnt + 6'd1;
				spiMiso  <= shiftReg[spiUnitPkg::wordBits-1];
				shiftReg <= {shiftReg[spiUnitPkg::wordBits-2:0], 1'b0};
			end

			if (rdTake)
				bufFull <= 1'b1;
		end
	end

	always_ff @(posedge sysClk)
	begin
		if (rdTake)
			bufData <= rdData;
	end

endmodule

`default_nettype wire

// ==== hw/spiUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module spiUnit
#(
	parameter int pBusAdrsBit = 16
)
(
	input  wire                             sysClk,
	input  wire                             rstN,
	input  wire                             spiSck,
	input  wire                             spiCs,
	input  wire                             spiMosi,
	output logic                            spiMiso,
	output logic [pBusAdrsBit-1:0]          usiAdrs,
	output logic [spiUnitPkg::wordBits-1:0] usiWd,
	output logic                            usiWEd,
	output logic                            usiREd,
	input  wire  [spiUnitPkg::wordBits-1:0] usiRd,
	output logic                            busMonopoly,
	output logic                            spiIntr
);

	// Synchronized pin events
	logic                             sckRise;
	logic                             sckFall;
	logic                             csActive;
	logic                             csFall;
	logic                             csRise;
	logic                             mosiBit;
	// Decode to execute
	logic                             cmdValid;
	spiUnitPkg::spiOpcode             cmdOp;
	logic [pBusAdrsBit-1:0]           cmdAdrs;
	logic [spiUnitPkg::lenBits-1:0]   cmdLen;
	logic                             cmdReady;
	logic                             wordValid;
	logic [spiUnitPkg::wordBits-1:0]  wordData;
	logic                             wordReady;
	logic                             frameAbort;
	// Execute to MISO
	logic                             rdValid;
	logic [spiUnitPkg::wordBits-1:0]  rdData;
	logic                             rdReady;

	//----------------------------------------------------------------------------
	// Pin synchronizers
	//----------------------------------------------------------------------------
	spiPinSync pinSync
	(
		.sysClk   (sysClk),
		.rstN     (rstN),
		.spiSck   (spiSck),
		.spiCs    (spiCs),
		.spiMosi  (spiMosi),
		.sckRise  (sckRise),
		.sckFall  (sckFall),
		.csActive (csActive),
		.csFall   (csFall),
		.csRise   (csRise),
		.mosiBit  (mosiBit)
	);

	//----------------------------------------------------------------------------
	// Frame decode
	//----------------------------------------------------------------------------
	spiFrameDecode #(
		.pBusAdrsBit (pBusAdrsBit)
	) frameDecode (
		.sysClk     (sysClk),
		.rstN       (rstN),
		.sckRise    (sckRise),
		.csActive   (csActive),
		.csFall     (csFall),
		.csRise     (csRise),
		.mosiBit    (mosiBit),
		.cmdValid   (cmdValid),
		.cmdOp      (cmdOp),
		.cmdAdrs    (cmdAdrs),
		.cmdLen     (cmdLen),
		.cmdReady   (cmdReady),
		.wordValid  (wordValid),
		.wordData   (wordData),
		.wordReady  (wordReady),
		.frameAbort (frameAbort)
	);

	//----------------------------------------------------------------------------
	// USI bus master
	//----------------------------------------------------------------------------
	usiBusExec #(
		.pBusAdrsBit (pBusAdrsBit)
	) busExec (
		.sysClk      (sysClk),
		.rstN        (rstN),
		.cmdValid    (cmdValid),
		.cmdOp       (cmdOp),
		.cmdAdrs     (cmdAdrs),
		.cmdLen      (cmdLen),
		.cmdReady    (cmdReady),
		.wordValid   (wordValid),
		.wordData    (wordData),
		.wordReady   (wordReady),
		.frameAbort  (frameAbort),
		.csRise      (csRise),
		.csActive    (csActive),
		.usiAdrs     (usiAdrs),
		.usiWd       (usiWd),
		.usiWEd      (usiWEd),
		.usiREd      (usiREd),
		.usiRd       (usiRd),
		.rdValid     (rdValid),
		.rdData      (rdData),
		.rdReady     (rdReady),
		.busMonopoly (busMonopoly),
		.spiIntr     (spiIntr)
	);

	// Read words back to the master
	misoResult misoOut
	(
		.sysClk   (sysClk),
		.rstN     (rstN),
		.sckFall  (sckFall),
		.csActive (csActive),
		.csFall   (csFall),
		.rdValid  (rdValid),
		.rdData   (rdData),
		.rdReady  (rdReady),
		.spiMiso  (spiMiso)
	);

endmodule

`default_nettype wire

// ==== tests/spiUnitTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module spiUnitTb;

	localparam int adrsBits   = 16;
	// Roughly twice the clock cycles used by all frames below
	localparam int cycleLimit = 60000;

	logic                  sysClk;
	logic                  rstN;
	logic                  spiSck;
	logic                  spiCs;
	logic                  spiMosi;
	logic                  spiMiso;
	logic [adrsBits-1:0]   usiAdrs;
	logic [31:0]           usiWd;
	logic                  usiWEd;
	logic                  usiREd;
	logic [31:0]           usiRd = '0;
	logic                  busMonopoly;
	logic                  spiIntr;

	// Bus memory model and its reference copy
	logic [31:0] mem [0:255];
	logic [31:0] refMem [0:255];
	// Expected strobe queues filled by the stimulus and drained by the checker
	logic [15:0] wrAdrsExp [0:255];
	logic [31:0] wrDataExp [0:255];
	logic [15:0] rdAdrsExp [0:255];
	int          wrTail = 0;
	int          wrHead = 0;
	int          rdTail = 0;
	int          rdHead = 0;
	logic        intrExp = 1'b0;
	logic [31:0] lfsr;
	int          cycles;
	int          busErrors = 0;
	int          frameErrors = 0;
	int          assertErrors = 0;

	spiUnit #(
		.pBusAdrsBit (adrsBits)
	) i_dut (
		.sysClk      (sysClk),
		.rstN        (rstN),
		.spiSck      (spiSck),
		.spiCs       (spiCs),
		.spiMosi     (spiMosi),
		.spiMiso     (spiMiso),
		.usiAdrs     (usiAdrs),
		.usiWd       (usiWd),
		.usiWEd      (usiWEd),
		.usiREd      (usiREd),
		.usiRd       (usiRd),
		.busMonopoly (busMonopoly),
		.spiIntr     (spiIntr)
	);

	initial
	begin
		sysClk = 1'b0;
		forever #4 sysClk = ~sysClk;
	end

	//----------------------------------------------------------------------------
	// Stimulus helpers
	//----------------------------------------------------------------------------

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit with the newest bit in the LSB
	function automatic logic [31:0] takeRandomBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Every byte depends on the full word index
	function automatic logic [31:0] fillWord(input logic [7:0] idx);
		return {idx, ~idx, idx ^ 8'h5a, idx + 8'h33};
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(posedge sysClk);
		#1;
	endtask

	// Mode 0 master sending MSB first with MOSI moving at the SCK fall
	task automatic shiftBits(input logic [31:0] txData, input int n, output logic [31:0] rxData);
		rxData = '0;
		for (int i = n - 1; i >= 0; i--)
		begin
			spiMosi = txData[i];
			waitCycles(4);
			rxData = {rxData[30:0], spiMiso};
			spiSck = 1'b1;
			waitCycles(4);
			spiSck = 1'b0;
		end
	endtask

	task automatic openFrame();
		spiCs = 1'b0;
		waitCycles(6);
	endtask

	// Interrupt expectation must be in place before CS rises
	task automatic closeFrame(input logic intrWanted);
		waitCycles(4);
		intrExp = intrWanted;
		spiCs = 1'b1;
		waitCycles(20);
	endtask

	task automatic sendHeader(input logic [7:0] op, input logic [15:0] adrs,
		input logic [15:0] len);
		logic [31:0] rxOp;
		logic [31:0] rxAdrs;
		logic [31:0] rxLen;
		shiftBits({24'd0, op}, 8, rxOp);
		shiftBits({16'd0, adrs}, 16, rxAdrs);
		shiftBits({16'd0, len}, 16, rxLen);
		headerQuiet: assert ((rxOp | rxAdrs | rxLen) == '0)
		else
		begin
			frameErrors++;
			$display("ERROR %0t: MISO not low during the frame header", $time);
		end
	endtask

	// Words past len are ignored and fewer than len abort the frame
	task automatic writeFrame(input logic [15:0] adrs, input int len, input int words,
		input int extraBits);
		logic [31:0] data;
		logic [31:0] rx;
		logic [15:0] wa;
		openFrame();
		sendHeader(spiUnitPkg::opWrite, adrs, 16'(len));
		for (int i = 0; i < words; i++)
		begin
			data = takeRandomBits(32);
			if (i < len)
			begin
				wa = adrs + 16'(4 * i);
				wrAdrsExp[wrTail] = wa;
				wrDataExp[wrTail] = data;
				wrTail++;
				refMem[wa[9:2]] = data;
			end
			shiftBits(data, 32, rx);
		end
		if (extraBits > 0)
			shiftBits(takeRandomBits(extraBits), extraBits, rx);
		closeFrame(words >= len);
	endtask

	// Words clocked past len must come back as zeros
	task automatic readFrame(input logic [15:0] adrs, input int len, input int words);
		logic [31:0] rx;
		logic [31:0] expWord;
		logic [15:0] wa;
		for (int i = 0; i < len; i++)
		begin
			rdAdrsExp[rdTail] = adrs + 16'(4 * i);
			rdTail++;
		end
		openFrame();
		sendHeader(spiUnitPkg::opRead, adrs, 16'(len));
		// Dummy byte
		shiftBits(32'd0, 8, rx);
		for (int i = 0; i < words; i++)
		begin
			wa = adrs + 16'(4 * i);
			expWord = (i < len) ? refMem[wa[9:2]] : 32'd0;
			shiftBits(32'd0, 32, rx);
			readWord: assert (rx == expWord)
			else
			begin
				frameErrors++;
				$display("ERROR %0t: MISO word %0d of read at %h is %h, expected %h",
					$time, i, adrs, rx, expWord);
			end
		end
		closeFrame(words >= len);
	endtask

	// Unknown opcode or zero length gives no bus access and a silent MISO
	task automatic silentFrame(input logic [7:0] op, input logic [15:0] adrs,
		input logic [15:0] len, input int chunks, input logic intrWanted);
		logic [31:0] rx;
		openFrame();
		sendHeader(op, adrs, len);
		for (int i = 0; i < chunks; i++)
		begin
			shiftBits(takeRandomBits(32), 32, rx);
			misoQuiet: assert (rx == '0)
			else
			begin
				frameErrors++;
				$display("ERROR %0t: MISO is %h in a frame without read data", $time, rx);
			end
		end
		closeFrame(intrWanted);
	endtask

	//----------------------------------------------------------------------------
	// Bus memory model with read data one cycle after the strobe
	//----------------------------------------------------------------------------
	always @(posedge sysClk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 256; i++)
				mem[i] <= fillWord(8'(i));
			usiRd <= '0;
		end
		else
		begin
			if (usiWEd)
				mem[usiAdrs[9:2]] <= usiWd;
			if (usiREd)
				usiRd <= mem[usiAdrs[9:2]];
		end
	end

	// Strobe contents sampled mid cycle
	always @(negedge sysClk)
	begin
		if (rstN && usiWEd)
		begin
			writeExpected: assert (wrHead != wrTail)
			else
			begin
				busErrors++;
				$display("Unexpected USI write strobe at %0t, address %h", $time, usiAdrs);
			end
			if (wrHead != wrTail)
			begin
				writeMatch: assert (usiAdrs == wrAdrsExp[wrHead] && usiWd == wrDataExp[wrHead])
				else
				begin
					busErrors++;
					$display("ERROR %0t: write %h to %h, expected %h to %h", $time,
						usiWd, usiAdrs, wrDataExp[wrHead], wrAdrsExp[wrHead]);
				end
				wrHead++;
			end
		end
		if (rstN && usiREd)
		begin
			readExpected: assert (rdHead != rdTail)
			else
			begin
				busErrors++;
				$display("Unexpected USI read strobe at %0t, address %h", $time, usiAdrs);
			end
			if (rdHead != rdTail)
			begin
				readMatch: assert (usiAdrs == rdAdrsExp[rdHead])
				else
				begin
					busErrors++;
					$display("ERROR %0t: read from %h, expected %h", $time,
						usiAdrs, rdAdrsExp[rdHead]);
				end
				rdHead++;
			end
		end
	end

	//----------------------------------------------------------------------------
	// Port protocol
	//----------------------------------------------------------------------------
	strobeExclusive: assert property (@(posedge sysClk) !(usiWEd && usiREd))
	else
	begin
		assertErrors++;
		$display("ERROR %0t: usiWEd and usiREd high together", $time);
	end

	resetQuiet: assert property (@(posedge sysClk)
		(!rstN && $past(!rstN)) |-> !(usiWEd || usiREd || busMonopoly || spiIntr))
	else
	begin
		assertErrors++;
		$display("ERROR %0t: strobe or flag active during reset", $time);
	end

	strobeOwned: assert property (@(posedge sysClk) disable iff (!rstN)
		(usiWEd || usiREd) |-> busMonopoly)
	else
	begin
		assertErrors++;
		$display("ERROR %0t: bus strobe while busMonopoly is low", $time);
	end

	// Follows the CS pin two cycles late
	monopolyWindow: assert property (@(posedge sysClk) disable iff (!rstN)
		busMonopoly == !$past(spiCs, 2))
	else
	begin
		assertErrors++;
		$display("ERROR %0t: busMonopoly is %b against the CS pin two cycles earlier",
			$time, busMonopoly);
	end

	// Pulse lands 3 cycles after the CS rise
	intrPulse: assert property (@(posedge sysClk) disable iff (!rstN)
		spiIntr == ($past(spiCs, 3) && !$past(spiCs, 4) && intrExp))
	else
	begin
		assertErrors++;
		$display("ERROR %0t: spiIntr is %b against a CS rise 3 cycles earlier, wanted %b",
			$time, spiIntr, intrExp);
	end

	initial
	begin
		cycles = 0;
		while (cycles < cycleLimit)
		begin
			@(posedge sysClk);
			cycles++;
		end
		$display("Timeout: the test did not finish within %0d clock cycles", cycleLimit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	//----------------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------------
	initial
	begin
		logic [31:0] rnd;
		logic [15:0] base;
		int          len;
		rstN    = 1'b0;
		spiCs   = 1'b1;
		spiSck  = 1'b0;
		spiMosi = 1'b0;
		lfsr    = 32'h2730_3f39;
		for (int i = 0; i < 256; i++)
			refMem[i] = fillWord(8'(i));
		repeat (10) @(posedge sysClk);
		#1;
		rstN = 1'b1;
		waitCycles(10);

		// Burst write then read back
		writeFrame(16'h0040, 4, 4, 0);
		readFrame(16'h0040, 4, 4);
		// Untouched words still hold the fill pattern
		readFrame(16'h0300, 3, 3);
		// Unknown opcode then zero length write and read
		silentFrame(8'h5a, 16'h0010, 16'd2, 2, 1'b0);
		silentFrame(spiUnitPkg::opWrite, 16'h0020, 16'd0, 1, 1'b1);
		silentFrame(spiUnitPkg::opRead, 16'h0020, 16'd0, 2, 1'b1);
		// CS rises in the middle of word 2 of 3
		writeFrame(16'h0080, 3, 1, 16);
		// One word past the length each way
		writeFrame(16'h00a0, 2, 3, 0);
		readFrame(16'h00a0, 2, 3);

		// Random bases and lengths
		repeat (7)
		begin
			rnd  = takeRandomBits(14);
			base = {rnd[13:0], 2'b00};
			len  = 1 + int'(takeRandomBits(2));
			writeFrame(base, len, len, 0);
			readFrame(base, len, len);
		end

		waitCycles(20);
		allWritesSeen: assert (wrHead == wrTail)
		else
		begin
			frameErrors++;
			$display("Missing USI writes: %0d expected strobes never came", wrTail - wrHead);
		end
		allReadsSeen: assert (rdHead == rdTail)
		else
		begin
			frameErrors++;
			$display("Missing USI reads: %0d expected strobes never came", rdTail - rdHead);
		end

		$display("Error counts: %0d bus, %0d frame, %0d protocol",
			busErrors, frameErrors, assertErrors);
		if (busErrors + frameErrors + assertErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== spiUnit.f ====
hw/spiUnitPkg.sv
hw/spiPinSync.sv
hw/spiFrameDecode.sv
hw/usiBusExec.sv
hw/misoResult.sv
hw/spiUnit.sv
tests/spiUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the spiUnit testbench with Verilator and runs it
# Exit status is nonzero when the run reports a failure

cd "$(dirname "$0")" || exit 1
set -o pipefail

logFile=sim.log
failMsg='*** TEST FAILED ***'
passMsg='*** TEST PASSED ***'

verilator --binary --assert -j 0 --top-module spiUnitTb -f spiUnit.f \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/VspiUnitTb 2>&1 | tee "$logFile" \
	|| { echo "Simulation ended abnormally"; exit 1; }

grep -qF "$failMsg" "$logFile" && { echo "Simulation reported a failure"; exit 1; }
grep -qF "$passMsg" "$logFile" || { echo "No pass verdict found in $logFile"; exit 1; }
echo "Simulation passed"
